// File: flist.f
src/isa_pkg.sv
src/cluster_pkg.sv
src/lane_issue_if.sv
src/lane_result_if.sv
src/issue_dispatch.sv
src/exec_lane.sv
src/cdb_arbiter.sv
src/exec_cluster.sv
test/exec_cluster_asserts.sv
test/exec_cluster_tb.sv

// File: Bender.yml
package:
  name: exec_cluster

sources:
  - files:
      - src/isa_pkg.sv
      - src/cluster_pkg.sv
      - src/lane_issue_if.sv
      - src/lane_result_if.sv
      - src/issue_dispatch.sv
      - src/exec_lane.sv
      - src/cdb_arbiter.sv
      - src/exec_cluster.sv
  - target: test
    files:
      - test/exec_cluster_asserts.sv
      - test/exec_cluster_tb.sv

// File: test/exec_cluster_tb.sv
`timescale 1ns/1ps

module exec_cluster_tb
	import isa_pkg::*;
	import cluster_pkg::*;
();

	localparam int num_rows = 24;
	localparam int num_tags = 2 ** tag_width;
	localparam int cycle_limit = num_rows * (mul_latency + num_lanes + 2) + 50;

	// leading rows run one at a time, so they finish in issue order
	localparam int num_serial = 8;

	// bound on the drain once the last row is in
	localparam int drain_limit = num_lanes * (mul_latency + num_lanes + 2);

	// stall_next: issue_stall expected high one cycle after this row
	typedef struct packed {
		rob_tag_t   tag;
		alu_func_e  func;
		xlen_t      opa;
		xlen_t      opb;
		logic [3:0] hold;
		logic       stall_next;
	} row_t;

	logic      clock, reset, issue_valid, issue_stall, cdb_valid;
	rob_tag_t  issue_tag, cdb_tag;
	alu_func_e issue_func;
	xlen_t     issue_opa, issue_opb, cdb_value;

	row_t stim [num_rows];

	// scoreboard by tag
	xlen_t    exp_value [num_tags];
	logic     is_mul [num_tags], issued [num_tags], seen [num_tags];
	int       accept_cycle [num_tags];
	int       seen_count, cycle_count;

	exec_cluster u_dut (.*);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	////////////////////////////////////////
	// reference model and checks
	////////////////////////////////////////

	function automatic xlen_t expected_result(alu_func_e func, xlen_t a, xlen_t b);
		logic [2*xlen-1:0] product;
		product = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
		case (func)
			func_add: return a + b;
			func_sub: return a - b;
			func_and: return a & b;
			func_or:  return a | b;
			func_xor: return a ^ b;
			func_sll: return a << b[shamt_width-1:0];
			func_srl: return a >> b[shamt_width-1:0];
			default:  return product[xlen-1:0];
		endcase
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	// tags scrambled from the row number, still unique
	task automatic add_row(input int idx, input alu_func_e func, input int hold, input logic sn);
		stim[idx].tag = rob_tag_t'(idx ^ 21);
		stim[idx].func = func;
		stim[idx].opa = $urandom();
		stim[idx].opb = $urandom();
		stim[idx].hold = 4'(hold);
		stim[idx].stall_next = sn;
	endtask

	task automatic build_table();
		// each simple op alone, then an isolated multiply
		add_row(0, func_add, 1, 0);
		add_row(1, func_sub, 1, 0);
		add_row(2, func_and, 1, 0);
		add_row(3, func_or, 1, 0);
		add_row(4, func_xor, 1, 0);
		add_row(5, func_sll, 1, 0);
		add_row(6, func_srl, 1, 0);
		add_row(7, func_mul, 12, 0);
		// four multiplies fill every lane
		for (int i = 8; i < 12; i++)
			add_row(i, func_mul, 0, i == 11);
		// mixed burst with no idle cycles
		add_row(12, func_add, 0, 0);
		add_row(13, func_sll, 0, 0);
		add_row(14, func_mul, 0, 0);
		add_row(15, func_sub, 0, 0);
		add_row(16, func_mul, 0, 0);
		add_row(17, func_xor, 0, 0);
		add_row(18, func_srl, 0, 0);
		add_row(19, func_mul, 0, 0);
		add_row(20, func_and, 0, 0);
		add_row(21, func_or, 0, 0);
		add_row(22, func_mul, 0, 0);
		add_row(23, func_add, 3, 0);
	endtask

	////////////////////////////////////////
	// cycle counter and timeout
	////////////////////////////////////////

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
			stop_with_failure($sformatf("timeout after %0d cycles", cycle_count));
	end

	// CDB monitor, sampled on the falling edge where outputs are stable
	always @(negedge clock) begin : monitor
		int min_lat;
		if (!reset && cdb_valid) begin
			if ($isunknown(cdb_tag))
				stop_with_failure("cdb_tag is unknown while cdb_valid is high");
			else if (!issued[cdb_tag])
				stop_with_failure($sformatf("tag %h on the CDB was never issued", cdb_tag));
			else if (seen[cdb_tag])
				stop_with_failure($sformatf("tag %h appeared on the CDB twice", cdb_tag));
			else begin
				// no contention yet, results follow the table
				if (seen_count < num_serial)
					check_tag("cdb_tag", cdb_tag, stim[seen_count].tag);
				check_value("cdb_value", cdb_value, exp_value[cdb_tag]);
				min_lat = is_mul[cdb_tag] ? mul_latency + 1 : 2;
				if (cycle_count - accept_cycle[cdb_tag] < min_lat)
					stop_with_failure($sformatf("tag %h finished too early", cdb_tag));
				seen[cdb_tag] = 1'b1;
				seen_count = seen_count + 1;
			end
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin : main
		int missing;
		int drain;
		row_t r;
		void'($urandom(32'hb129_d401));
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_tag = '0;
		issue_func = func_add;
		issue_opa = '0;
		issue_opb = '0;
		seen_count = 0;
		cycle_count = 0;
		missing = 0;
		drain = 0;
		for (int t = 0; t < num_tags; t++) begin
			issued[t] = 1'b0;
			seen[t] = 1'b0;
		end
		build_table();

		// outputs stay quiet during and right after reset
		repeat (4) begin
			@(negedge clock);
			check_flag("issue_stall", issue_stall, 1'b0);
			check_flag("cdb_valid", cdb_valid, 1'b0);
		end
		reset = 1'b0;
		@(negedge clock);
		check_flag("issue_stall", issue_stall, 1'b0);
		check_flag("cdb_valid", cdb_valid, 1'b0);

		for (int i = 0; i < num_rows; i++) begin
			r = stim[i];
			@(negedge clock);
			if (i > 0 && stim[i-1].stall_next)
				check_flag("issue_stall", issue_stall, 1'b1);
			issue_valid = 1'b1;
			issue_tag = r.tag;
			issue_func = r.func;
			issue_opa = r.opa;
			issue_opb = r.opb;
			// hold the op until a lane frees up
			while (issue_stall)
				@(negedge clock);
			exp_value[r.tag] = expected_result(r.func, r.opa, r.opb);
			is_mul[r.tag] = (r.func == func_mul);
			accept_cycle[r.tag] = cycle_count + 1;
			issued[r.tag] = 1'b1;
			repeat (r.hold) begin
				@(negedge clock);
				issue_valid = 1'b0;
			end
		end
		@(negedge clock);
		issue_valid = 1'b0;

		// bounded drain, then a few spare cycles to catch a late duplicate
		while (seen_count < num_rows && drain < drain_limit) begin
			@(negedge clock);
			drain = drain + 1;
		end
		repeat (2 * num_lanes) @(negedge clock);
		for (int i = 0; i < num_rows; i++)
			if (!seen[stim[i].tag])
				missing = missing + 1;
		if (missing == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			stop_with_failure($sformatf("%0d tags never appeared on the CDB", missing));
		end
	end

endmodule

// File: test/exec_cluster_asserts.sv
`timescale 1ns/1ps

module exec_cluster_asserts
	import isa_pkg::*;
	import cluster_pkg::*;
(
	input logic     clock,
	input logic     reset,
	input logic     issue_valid,
	input rob_tag_t issue_tag,
	input logic     issue_stall,
	input logic     cdb_valid,
	input rob_tag_t cdb_tag,
	input xlen_t    cdb_value
);

	// accept edge as seen from the issue ports
	logic accept;
	assign accept = issue_valid && !issue_stall;

	// broadcast payload must be known
	cdb_known: assert property (@(posedge clock) disable iff (reset)
		cdb_valid |-> !$isunknown({cdb_tag, cdb_value}))
		else $error("cdb payload has X while cdb_valid is high");

	// first cycle out of reset
	reset_quiet: assert property (@(posedge clock)
		$fell(reset) |-> (!issue_stall && !cdb_valid))
		else $error("issue_stall or cdb_valid high right after reset");

	// earliest broadcast is two edges after accept
	no_early_1: assert property (@(posedge clock) disable iff (reset)
		accept |=> !(cdb_valid && (cdb_tag == $past(issue_tag))))
		else $error("tag on the bus one cycle after accept");
	no_early_2: assert property (@(posedge clock) disable iff (reset)
		accept |=> ##1 !(cdb_valid && (cdb_tag == $past(issue_tag, 2))))
		else $error("tag on the bus too early after accept");

endmodule

bind exec_cluster exec_cluster_asserts u_asserts (
	.clock       (clock),
	.reset       (reset),
	.issue_valid (issue_valid),
	.issue_tag   (issue_tag),
	.issue_stall (issue_stall),
	.cdb_valid   (cdb_valid),
	.cdb_tag     (cdb_tag),
	.cdb_value   (cdb_value)
);

// File: src/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster
	import isa_pkg::*;
	import cluster_pkg::*;
(
	input  logic      clock,
	input  logic      reset,

	// issue side
	input  logic      issue_valid,
	input  rob_tag_t  issue_tag,
	input  alu_func_e issue_func,
	input  xlen_t     issue_opa,
	input  xlen_t     issue_opb,
	output logic      issue_stall,

	// common data bus
	output logic      cdb_valid,
	output rob_tag_t  cdb_tag,
	output xlen_t     cdb_value
);

	// one issue link and one result link per lane
	lane_issue_if  issue_bus [num_lanes] ();
	lane_result_if result_bus [num_lanes] ();

	////////////////////////////////////////
	// dispatch
	////////////////////////////////////////

	// picks lowest idle lane, stalls when all busy
	issue_dispatch u_dispatch (
		.issue_valid (issue_valid),
		.issue_tag   (issue_tag),
		.issue_func  (issue_func),
		.issue_opa   (issue_opa),
		.issue_opb   (issue_opb),
		.issue_stall (issue_stall),
		.lanes       (issue_bus)
	);

	////////////////////////////////////////
	// execute lanes
	////////////////////////////////////////

	for (genvar i = 0; i < num_lanes; i++) begin : g_lane
		exec_lane u_lane (
			.clock  (clock),
			.reset  (reset),
			.issue  (issue_bus[i]),
			.result (result_bus[i])
		);
	end

	////////////////////////////////////////
	// completion
	////////////////////////////////////////

	// round-robin drain, registered CDB
	cdb_arbiter u_cdb (
		.clock     (clock),
		.reset     (reset),
		.lanes     (result_bus),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.cdb_value (cdb_value)
	);

endmodule

// File: src/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter
	import isa_pkg::*;
	import cluster_pkg::*;
(
	input  logic           clock,
	input  logic           reset,
	lane_result_if.arbiter lanes [num_lanes],
	output logic           cdb_valid,
	output rob_tag_t       cdb_tag,
	output xlen_t          cdb_value
);

	// per-lane taps
	lane_mask_t done_mask;
	lane_mask_t grant_mask;
	rob_tag_t   lane_tag [num_lanes];
	xlen_t      lane_value [num_lanes];

	// round-robin pointer and current pick
	lane_idx_t ptr_q;
	lane_idx_t sel;
	logic      found;

	for (genvar i = 0; i < num_lanes; i++) begin : g_tap
		assign done_mask[i] = lanes[i].done;
		assign lane_tag[i] = lanes[i].tag;
		assign lane_value[i] = lanes[i].value;
		assign lanes[i].grant = grant_mask[i];
	end

	////////////////////////////////////////
	// round-robin pick
	////////////////////////////////////////

	// first done lane at or after the pointer
	always_comb begin : rr_pick
		lane_idx_t cand;
		sel = ptr_q;
		found = 1'b0;
		for (int off = 0; off < num_lanes; off++) begin
			cand = lane_idx_t'((int'(ptr_q) + off) % num_lanes);
			if (!found && done_mask[cand]) begin
				sel = cand;
				found = 1'b1;
			end
		end
	end

	// one grant per cycle at most
	assign grant_mask = found ? (lane_mask_t'(1) << sel) : '0;

	////////////////////////////////////////
	// CDB register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			cdb_valid <= 1'b0;
			ptr_q <= '0;
		end else begin
			cdb_valid <= found;
			// next search starts past the winner
			if (found) begin
				ptr_q <= lane_idx_t'((int'(sel) + 1) % num_lanes);
			end
		end
	end

	// broadcast payload, qualified by cdb_valid
	always_ff @(posedge clock) begin
		if (found) begin
			cdb_tag <= lane_tag[sel];
			cdb_value <= lane_value[sel];
		end
	end

endmodule

// File: src/exec_lane.sv
`timescale 1ns/1ps

module exec_lane
	import isa_pkg::*;
	import cluster_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	lane_issue_if.lane  issue,
	lane_result_if.lane result
);

	// control state
	logic       busy_q;
	logic       done_q;
	lat_count_t count_q;

	// held operation and result
	rob_tag_t  tag_q;
	alu_func_e func_q;
	xlen_t     opa_q;
	xlen_t     opb_q;
	xlen_t     value_q;

	// function unit and latency helpers
	xlen_t      alu_out;
	lat_count_t start_lat;
	logic       finish;

	////////////////////////////////////////
	// latency
	////////////////////////////////////////

	// simple ops take one cycle, multiply stands in for the mult channel
	assign start_lat = (issue.func == func_mul) ? lat_count_t'(mul_latency)
	                                            : lat_count_t'(1);

	// last counting cycle, result captured at this edge
	assign finish = busy_q && (count_q == lat_count_t'(1));

	// a granted lane reads as free so it can restart right away
	assign issue.busy = busy_q && !result.grant;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			count_q <= '0;
		end else if (issue.start) begin
			busy_q <= 1'b1;
			done_q <= 1'b0;
			count_q <= start_lat;
		end else if (result.grant) begin
			// result left on the CDB
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			if (count_q != '0) begin
				count_q <= count_q - lat_count_t'(1);
			end
			if (finish) begin
				done_q <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////

	always_comb begin
		case (func_q)
			func_add: alu_out = opa_q + opb_q;
			func_sub: alu_out = opa_q - opb_q;
			func_and: alu_out = opa_q & opb_q;
			func_or:  alu_out = opa_q | opb_q;
			func_xor: alu_out = opa_q ^ opb_q;
			func_sll: alu_out = opa_q << opb_q[shamt_width-1:0];
			func_srl: alu_out = opa_q >> opb_q[shamt_width-1:0];
			// low word of the product only
			func_mul: alu_out = xlen_t'(opa_q * opb_q);
			default:  alu_out = '0;
		endcase
	end

	// operands latched on start, result on the finishing edge
	always_ff @(posedge clock) begin
		if (issue.start) begin
			tag_q <= issue.tag;
			func_q <= issue.func;
			opa_q <= issue.opa;
			opb_q <= issue.opb;
		end
		if (finish) begin
			value_q <= alu_out;
		end
	end

	// held steady until grant
	assign result.done = done_q;
	assign result.tag = tag_q;
	assign result.value = value_q;

endmodule

// File: src/issue_dispatch.sv
`timescale 1ns/1ps

module issue_dispatch
	import isa_pkg::*;
	import cluster_pkg::*;
(
	input  logic          issue_valid,
	input  rob_tag_t      issue_tag,
	input  alu_func_e     issue_func,
	input  xlen_t         issue_opa,
	input  xlen_t         issue_opb,
	output logic          issue_stall,
	lane_issue_if.dispatch lanes [num_lanes]
);

	// busy bits gathered from every lane
	lane_mask_t busy_mask;
	lane_mask_t free_mask;

	// lowest idle lane
	lane_idx_t pick;
	logic      any_free;

	////////////////////////////////////////
	// lane taps
	////////////////////////////////////////

	for (genvar i = 0; i < num_lanes; i++) begin : g_tap
		assign busy_mask[i] = lanes[i].busy;

		// operation fields fan out to all lanes
		assign lanes[i].tag = issue_tag;
		assign lanes[i].func = issue_func;
		assign lanes[i].opa = issue_opa;
		assign lanes[i].opb = issue_opb;

		// only the chosen lane sees start
		assign lanes[i].start = issue_valid && any_free && (pick == lane_idx_t'(i));
	end

	////////////////////////////////////////
	// priority encoder
	////////////////////////////////////////

	assign free_mask = ~busy_mask;
	assign any_free = |free_mask;

	// scan top down so lane 0 wins ties
	always_comb begin
		pick = '0;
		for (int i = num_lanes - 1; i >= 0; i--) begin
			if (free_mask[i]) begin
				pick = lane_idx_t'(i);
			end
		end
	end

	// no queue here, source holds its op while this is high
	assign issue_stall = &busy_mask;

endmodule

// File: src/lane_result_if.sv
`timescale 1ns/1ps

// one finished result waiting for the CDB
interface lane_result_if
	import isa_pkg::*;
	import cluster_pkg::*;
();

	// level, held with tag/value until granted
	logic     done;
	rob_tag_t tag;
	xlen_t    value;

	// single-cycle pulse from the arbiter
	logic     grant;

	// execute lane side
	modport lane (output done, tag, value, input grant);

	// CDB arbiter side
	modport arbiter (input done, tag, value, output grant);

endinterface

// File: src/lane_issue_if.sv
`timescale 1ns/1ps

// one issued operation headed to one lane
interface lane_issue_if
	import isa_pkg::*;
	import cluster_pkg::*;
();

	// one-cycle strobe, only toward an idle lane
	logic      start;
	rob_tag_t  tag;
	alu_func_e func;
	xlen_t     opa;
	xlen_t     opb;

	// lane occupied, can't take a new op
	logic      busy;

	// dispatcher side
	modport dispatch (output start, tag, func, opa, opb, input busy);

	// execute lane side
	modport lane (input start, tag, func, opa, opb, output busy);

endinterface

// File: src/cluster_pkg.sv
package cluster_pkg;

	////////////////////////////////////////
	// lane cluster sizing
	////////////////////////////////////////

	// number of identical execute lanes
	localparam int num_lanes = 4;

	// reorder-buffer tag width
	localparam int tag_width = 5;

	// cycles a multiply occupies a lane before done
	localparam int mul_latency = 4;

	// counter must hold mul_latency itself
	localparam int lat_width = $clog2(mul_latency + 1);

	////////////////////////////////////////
	// derived types
	////////////////////////////////////////

	typedef logic [tag_width-1:0] rob_tag_t;
	typedef logic [lat_width-1:0] lat_count_t;

	// lane number and one-bit-per-lane mask
	typedef logic [$clog2(num_lanes)-1:0] lane_idx_t;
	typedef logic [num_lanes-1:0] lane_mask_t;

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////

	// word width of operands and results
	localparam int xlen = 32;

	// shifts only look at the low bits of operand b
	localparam int shamt_width = 5;

	// one operand or result word
	typedef logic [xlen-1:0] xlen_t;

	////////////////////////////////////////
	// operation codes
	////////////////////////////////////////

	// multiply is the only multi-cycle op
	typedef enum logic [2:0] {
		func_add = 3'd0,
		func_sub = 3'd1,
		func_and = 3'd2,
		func_or  = 3'd3,
		func_xor = 3'd4,
		func_sll = 3'd5,
		func_srl = 3'd6,
		func_mul = 3'd7
	} alu_func_e;

endpackage
